// File: Makefile
TOP = tb_fetch

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100

obj_dir/V$(TOP): vlog.f hdl/*.sv tb/*.sv
	verilator --binary --timing --assert -Wno-fatal -j 0 -f vlog.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -Wall -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// File: hdl/fetch_pkg.sv
// Fetch stage shared types
package fetch_pkg;

   //////////////////////////////
   // Widths
   //////////////////////////////
   typedef logic [15:0] word_t;
   typedef logic [15:0] addr_t;
   typedef logic [2:0]  reg_idx_t;
   typedef logic [4:0]  opcode_t;

   // Control flow class of a fetched opcode
   typedef enum logic [1:0] {seq, jump, branch, halt} flow_class_e;

   // Fetch-to-decode pipe register content
   typedef struct packed {
      word_t instr;
      addr_t incr_pc;
   } issue_s;

   // Source registers read by an instruction
   typedef struct packed {
      reg_idx_t rs;
      reg_idx_t rt;
      logic     rs_valid;
      logic     rt_valid;
   } src_s;

   // Bubble word, opcode 00001
   localparam word_t NOP_WORD = 16'h0800;
   localparam addr_t PC_STEP  = 16'd2;

   //////////////////////////////
   // Decode helpers
   //////////////////////////////
   // Opcode sits in the top five bits
   function automatic opcode_t opcode_of(word_t w);
      return w[15:11];
   endfunction

   function automatic flow_class_e classify(opcode_t op);
      if (op == 5'b00000) return halt;
      if (op[4:2] == 3'b001) return jump;
      if (op[4:2] == 3'b011) return branch;
      return seq;
   endfunction

   function automatic src_s sources_of(word_t w);
      src_s s;
      s.rs = w[10:8];
      s.rt = w[7:5];
      // No rs for 000 group and for immediate jumps (001, bit 11 low)
      s.rs_valid = (w[15:13] != 3'b000) && !((w[15:13] == 3'b001) && !w[11]);
      // Register-register ALU, compare and branch-on-reg forms read rt
      s.rt_valid = (w[15:12] == 4'b1101) || (w[15:13] == 3'b111);
      return s;
   endfunction

endpackage

// File: hdl/fetch_stage.sv
// Instruction fetch stage top
`timescale 1ns/1ps

module fetch_stage #(
   parameter int DEPTH_LOG2    = 10,
   parameter int RAW_WINDOW    = 3,
   parameter int JUMP_SHADOW   = 3,
   parameter int BRANCH_SHADOW = 2,
   parameter int DUMP_DELAY    = 5
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                redirect,
   input  fetch_pkg::addr_t    redirect_pc,
   input  fetch_pkg::reg_idx_t dst,
   input  logic                dst_valid,
   input  logic                load_en,
   input  fetch_pkg::addr_t    load_addr,
   input  fetch_pkg::word_t    load_data,
   output fetch_pkg::issue_s   issue,
   output logic                dump
);

   fetch_pkg::addr_t   pc;
   fetch_pkg::addr_t   next_seq;
   fetch_pkg::word_t   word;
   fetch_pkg::opcode_t opcode;
   fetch_pkg::src_s    src;
   logic               raw;
   logic               jump_shadow;
   logic               branch_shadow;
   logic               halted;
   logic               hold;
   logic               issued;
   logic               pc_redirect;

   // Fields of the fetched word
   assign opcode = fetch_pkg::opcode_of(word);
   assign src    = fetch_pkg::sources_of(word);

   // Redirects ignored once halted
   assign pc_redirect = redirect & ~halted;

   //////////////////////////////
   // Fetch path
   //////////////////////////////
   pc_unit u_pc (
      .clk(clk), .rst(rst), .hold(hold), .redirect(pc_redirect),
      .redirect_pc(redirect_pc), .pc(pc), .next_seq(next_seq)
   );

   instr_mem #(.DEPTH_LOG2(DEPTH_LOG2)) u_imem (
      .clk(clk), .addr(pc), .rdata(word), .load_en(load_en),
      .load_addr(load_addr), .load_data(load_data)
   );

   //////////////////////////////
   // Side checks and issue
   //////////////////////////////
   raw_detector #(.RAW_WINDOW(RAW_WINDOW)) u_raw (
      .clk(clk), .rst(rst), .src(src), .dst(dst), .dst_valid(dst_valid), .raw(raw)
   );

   flow_sequencer #(
      .JUMP_SHADOW(JUMP_SHADOW), .BRANCH_SHADOW(BRANCH_SHADOW), .DUMP_DELAY(DUMP_DELAY)
   ) u_flow (
      .clk(clk), .rst(rst), .opcode(opcode), .issued(issued),
      .jump_shadow(jump_shadow), .branch_shadow(branch_shadow),
      .halted(halted), .dump(dump)
   );

   issue_ctrl u_issue (
      .clk(clk), .rst(rst), .word(word), .next_seq(next_seq), .raw(raw),
      .jump_shadow(jump_shadow), .branch_shadow(branch_shadow), .halted(halted),
      .hold(hold), .issued(issued), .issue(issue)
   );

endmodule

// File: hdl/flow_sequencer.sv
// Control flow sequencer
`timescale 1ns/1ps

module flow_sequencer #(
   parameter int JUMP_SHADOW   = 3,
   parameter int BRANCH_SHADOW = 2,
   parameter int DUMP_DELAY    = 5
) (
   input  logic               clk,
   input  logic               rst,
   input  fetch_pkg::opcode_t opcode,
   input  logic               issued,
   output logic               jump_shadow,
   output logic               branch_shadow,
   output logic               halted,
   output logic               dump
);

   localparam int JW = $clog2(JUMP_SHADOW + 1);
   localparam int BW = $clog2(BRANCH_SHADOW + 1);
   localparam int DW = $clog2(DUMP_DELAY + 1);

   typedef enum logic [1:0] {run, draining, dumped} halt_state_e;

   fetch_pkg::flow_class_e cls;
   logic [JW-1:0]          jump_cnt;
   logic [BW-1:0]          branch_cnt;
   logic [DW-1:0]          dump_cnt;
   halt_state_e            state;

   // Class of the word under the PC
   assign cls = fetch_pkg::classify(opcode);

   //////////////////////////////
   // Shadow counters
   //////////////////////////////
   // Loaded only when the word really goes out, so a stalled
   // jump or branch starts nothing yet
   always_ff @(posedge clk) begin
      if (rst) begin
         jump_cnt   <= '0;
         branch_cnt <= '0;
      end else begin
         if (issued && (cls == fetch_pkg::jump)) begin
            jump_cnt <= JW'(JUMP_SHADOW);
         end else if (jump_cnt != '0) begin
            jump_cnt <= jump_cnt - 1'b1;
         end
         if (issued && (cls == fetch_pkg::branch)) begin
            branch_cnt <= BW'(BRANCH_SHADOW);
         end else if (branch_cnt != '0) begin
            branch_cnt <= branch_cnt - 1'b1;
         end
      end
   end

   assign jump_shadow   = (jump_cnt != '0);
   assign branch_shadow = (branch_cnt != '0);

   //////////////////////////////
   // Halt and dump
   //////////////////////////////
   // Delay loaded one short, the state change adds the last cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= run;
         dump_cnt <= '0;
      end else begin
         case (state)
            run: begin
               if (issued && (cls == fetch_pkg::halt)) begin
                  state    <= draining;
                  dump_cnt <= DW'(DUMP_DELAY - 1);
               end
            end
            draining: begin
               if (dump_cnt == '0) begin
                  state <= dumped;
               end else begin
                  dump_cnt <= dump_cnt - 1'b1;
               end
            end
            // Sticky until reset
            default: state <= dumped;
         endcase
      end
   end

   assign halted = (state != run);
   assign dump   = (state == dumped);

endmodule

// File: hdl/instr_mem.sv
// Instruction memory
`timescale 1ns/1ps

module instr_mem #(
   parameter int DEPTH_LOG2 = 10
) (
   input  logic             clk,
   input  fetch_pkg::addr_t addr,
   output fetch_pkg::word_t rdata,
   input  logic             load_en,
   input  fetch_pkg::addr_t load_addr,
   input  fetch_pkg::word_t load_data
);

   localparam int DEPTH = 2 ** DEPTH_LOG2;

   // Word array, no reset on contents
   fetch_pkg::word_t mem [DEPTH];

   // Byte address to word index, bit 0 dropped
   logic [DEPTH_LOG2-1:0] rd_idx;
   logic [DEPTH_LOG2-1:0] wr_idx;

   assign rd_idx = addr[DEPTH_LOG2:1];
   assign wr_idx = load_addr[DEPTH_LOG2:1];

   //////////////////////////////
   // Read port
   //////////////////////////////
   // Same cycle as the PC, feeds the issue mux directly
   assign rdata = mem[rd_idx];

   //////////////////////////////
   // Load port
   //////////////////////////////
   // One word per clock while filling the program
   always_ff @(posedge clk) begin
      if (load_en) begin
         mem[wr_idx] <= load_data;
      end
   end

endmodule

// File: hdl/issue_ctrl.sv
// Issue controller and decode pipe register
`timescale 1ns/1ps

module issue_ctrl (
   input  logic              clk,
   input  logic              rst,
   input  fetch_pkg::word_t  word,
   input  fetch_pkg::addr_t  next_seq,
   input  logic              raw,
   input  logic              jump_shadow,
   input  logic              branch_shadow,
   input  logic              halted,
   output logic              hold,
   output logic              issued,
   output fetch_pkg::issue_s issue
);

   logic              stall;
   fetch_pkg::issue_s issue_d;

   //////////////////////////////
   // Stall decision
   //////////////////////////////
   // Any hazard, an open shadow, or a halt already out
   assign stall = raw | jump_shadow | branch_shadow | halted;

   // PC waits on the same condition
   assign hold = stall;

   // Word leaves fetch this cycle
   assign issued = ~stall;

   //////////////////////////////
   // Pipe register
   //////////////////////////////
   // Bubble in place of the word when stalled
   always_comb begin
      issue_d.instr   = issued ? word : fetch_pkg::NOP_WORD;
      issue_d.incr_pc = next_seq;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         issue <= '0;
      end else begin
         issue <= issue_d;
      end
   end

endmodule

// File: hdl/pc_unit.sv
// Program counter
`timescale 1ns/1ps

module pc_unit (
   input  logic             clk,
   input  logic             rst,
   input  logic             hold,
   input  logic             redirect,
   input  fetch_pkg::addr_t redirect_pc,
   output fetch_pkg::addr_t pc,
   output fetch_pkg::addr_t next_seq
);

   fetch_pkg::addr_t pc_q;
   fetch_pkg::addr_t pc_d;

   //////////////////////////////
   // Next address
   //////////////////////////////
   // Sequential successor, also goes down the pipe as incr_pc
   assign next_seq = pc_q + fetch_pkg::PC_STEP;

   // Redirect from execute wins over any stall
   always_comb begin
      if (redirect) begin
         pc_d = redirect_pc;
      end else if (hold) begin
         pc_d = pc_q;
      end else begin
         pc_d = next_seq;
      end
   end

   //////////////////////////////
   // PC register
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         pc_q <= '0;
      end else begin
         pc_q <= pc_d;
      end
   end

   // Straight to the memory address
   assign pc = pc_q;

endmodule

// File: hdl/raw_detector.sv
// Read-after-write hazard detector
`timescale 1ns/1ps

module raw_detector #(
   parameter int RAW_WINDOW = 3
) (
   input  logic                clk,
   input  logic                rst,
   input  fetch_pkg::src_s     src,
   input  fetch_pkg::reg_idx_t dst,
   input  logic                dst_valid,
   output logic                raw
);

   // One remembered destination report
   typedef struct packed {
      fetch_pkg::reg_idx_t idx;
      logic                vld;
   } dst_entry_s;

   dst_entry_s                  live;
   dst_entry_s [RAW_WINDOW-1:0] hist;

   assign live.idx = dst;
   assign live.vld = dst_valid;

   //////////////////////////////
   // Destination window
   //////////////////////////////
   // Entry 0 is the most recent past cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < RAW_WINDOW; i++) begin
            hist[i] <= '0;
         end
      end else begin
         hist[0] <= live;
         for (int i = 1; i < RAW_WINDOW; i++) begin
            hist[i] <= hist[i-1];
         end
      end
   end

   //////////////////////////////
   // Source compare
   //////////////////////////////
   // Either valid source hitting a valid entry
   function automatic logic hits(dst_entry_s e, fetch_pkg::src_s s);
      logic rs_hit;
      logic rt_hit;
      rs_hit = s.rs_valid && (s.rs == e.idx);
      rt_hit = s.rt_valid && (s.rt == e.idx);
      return e.vld && (rs_hit || rt_hit);
   endfunction

   // Current report counts too, its writer is still in flight
   always_comb begin
      raw = hits(live, src);
      for (int i = 0; i < RAW_WINDOW; i++) begin
         raw = raw | hits(hist[i], src);
      end
   end

endmodule

// File: tb/clk_gen.sv
// Clock and reset source
`timescale 1ns/1ps

module clk_gen #(
   parameter real PERIOD       = 8.0,
   parameter int  RESET_CYCLES = 16
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2.0) clk = ~clk;
   end

   // Reset drops on a falling edge, clear of the sampling edge
   initial begin
      rst <= 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst <= 1'b0;
   end

endmodule

// File: tb/fetch_assert.sv
// Fetch stage port checks
`timescale 1ns/1ps

module fetch_assert #(
   parameter int DEPTH_LOG2    = 10,
   parameter int RAW_WINDOW    = 3,
   parameter int JUMP_SHADOW   = 3,
   parameter int BRANCH_SHADOW = 2,
   parameter int DUMP_DELAY    = 5
) (
   input logic                clk,
   input logic                rst,
   input logic                redirect,
   input fetch_pkg::addr_t    redirect_pc,
   input fetch_pkg::reg_idx_t dst,
   input logic                dst_valid,
   input logic                load_en,
   input fetch_pkg::addr_t    load_addr,
   input fetch_pkg::word_t    load_data,
   input fetch_pkg::issue_s   issue,
   input logic                dump
);

   // One destination report as seen on the ports
   typedef struct packed {
      fetch_pkg::reg_idx_t idx;
      logic                vld;
   } dst_rec_s;

   // Count of failed checks
   int errors = 0;

   dst_rec_s [RAW_WINDOW:0] win;
   fetch_pkg::word_t        image [2 ** DEPTH_LOG2];
   fetch_pkg::addr_t        fetch_pc;
   fetch_pkg::word_t        expect_word;
   fetch_pkg::flow_class_e  cls;
   fetch_pkg::src_s         src;
   fetch_pkg::addr_t        incr_q;
   fetch_pkg::addr_t        target_q;
   fetch_pkg::addr_t        expect_pc;
   logic                    armed;
   logic                    real_q;
   logic                    redir_q;
   logic                    redir_qq;
   logic                    pend;
   logic                    real_now;
   logic                    bubble;
   logic                    raw_seen;
   int                      shadow_left;
   int                      halt_age;

   task automatic note_failure(string what);
      $error("FAIL at %0t: %s", $time, what);
      errors++;
   endtask

   //////////////////////////////
   // Program image
   //////////////////////////////
   // Copy of the program as written through the fill port
   always_ff @(posedge clk) begin
      if (load_en) begin
         image[load_addr[DEPTH_LOG2:1]] <= load_data;
      end
   end

   //////////////////////////////
   // Reference tracking
   //////////////////////////////
   // Issue register holds zeros for one sample after reset
   assign real_now = armed && (issue.instr != fetch_pkg::NOP_WORD);
   assign bubble   = armed && (issue.instr == fetch_pkg::NOP_WORD);
   assign cls      = fetch_pkg::classify(fetch_pkg::opcode_of(issue.instr));

   // Word under the PC in the fetch cycle, a bubble keeps the held PC
   assign fetch_pc    = issue.incr_pc - fetch_pkg::PC_STEP;
   assign expect_word = image[fetch_pc[DEPTH_LOG2:1]];
   assign src         = fetch_pkg::sources_of(expect_word);

   // Reports from the fetch cycle and the RAW_WINDOW cycles before it
   always_comb begin
      raw_seen = 1'b0;
      for (int i = 0; i <= RAW_WINDOW; i++) begin
         raw_seen = raw_seen | (win[i].vld && src.rs_valid && (src.rs == win[i].idx));
         raw_seen = raw_seen | (win[i].vld && src.rt_valid && (src.rt == win[i].idx));
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         win         <= '0;
         armed       <= 1'b0;
         real_q      <= 1'b0;
         incr_q      <= '0;
         redir_q     <= 1'b0;
         redir_qq    <= 1'b0;
         target_q    <= '0;
         pend        <= 1'b0;
         expect_pc   <= '0;
         shadow_left <= 0;
         halt_age    <= 0;
      end else begin
         win      <= {win[RAW_WINDOW-1:0], dst, dst_valid};
         armed    <= 1'b1;
         real_q   <= real_now;
         incr_q   <= issue.incr_pc;
         redir_q  <= redirect;
         redir_qq <= redir_q;
         target_q <= redirect_pc;
         // Newer redirect replaces an unmet one
         if (redir_q) begin
            pend      <= 1'b1;
            expect_pc <= target_q + fetch_pkg::PC_STEP;
         end else if (real_now) begin
            pend <= 1'b0;
         end
         if (real_now && (cls == fetch_pkg::jump)) begin
            shadow_left <= JUMP_SHADOW;
         end else if (real_now && (cls == fetch_pkg::branch)) begin
            shadow_left <= BRANCH_SHADOW;
         end else if (shadow_left != 0) begin
            shadow_left <= shadow_left - 1;
         end
         // Age of the halt issue, saturating at the dump point
         if (halt_age != 0) begin
            if (halt_age < DUMP_DELAY) halt_age <= halt_age + 1;
         end else if (real_now && (cls == fetch_pkg::halt)) begin
            halt_age <= 1;
         end
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////
   assert property (@(posedge clk) rst |=> ((issue == '0) && !dump))
      else note_failure("issue or dump not cleared by reset");
   assert property (@(posedge clk) disable iff (rst)
      real_now |-> (issue.instr == expect_word))
      else note_failure("issued word is not the memory word at its PC");
   assert property (@(posedge clk) disable iff (rst)
      (real_now && real_q && !redir_qq) |-> (issue.incr_pc == incr_q + fetch_pkg::PC_STEP))
      else note_failure("incr_pc did not step by 2");
   assert property (@(posedge clk) disable iff (rst) real_now |-> !raw_seen)
      else note_failure("word issued over a pending register write");
   assert property (@(posedge clk) disable iff (rst) (shadow_left != 0) |-> bubble)
      else note_failure("word issued inside a jump or branch shadow");
   assert property (@(posedge clk) disable iff (rst)
      (bubble && (shadow_left == 0) && (halt_age == 0)) |-> raw_seen)
      else note_failure("bubble with no hazard, shadow or halt behind it");
   assert property (@(posedge clk) disable iff (rst)
      (pend && real_now) |-> (issue.incr_pc == expect_pc))
      else note_failure("first word after redirect has wrong incr_pc");
   assert property (@(posedge clk) disable iff (rst) (halt_age != 0) |-> bubble)
      else note_failure("word issued after halt");
   assert property (@(posedge clk) disable iff (rst) (halt_age < DUMP_DELAY) |-> !dump)
      else note_failure("dump high too early");
   assert property (@(posedge clk) disable iff (rst) (halt_age >= DUMP_DELAY) |-> dump)
      else note_failure("dump low after the halt delay");

endmodule

bind fetch_stage fetch_assert #(
   .DEPTH_LOG2(DEPTH_LOG2), .RAW_WINDOW(RAW_WINDOW), .JUMP_SHADOW(JUMP_SHADOW),
   .BRANCH_SHADOW(BRANCH_SHADOW), .DUMP_DELAY(DUMP_DELAY)
) chk (
   .clk(clk), .rst(rst), .redirect(redirect), .redirect_pc(redirect_pc),
   .dst(dst), .dst_valid(dst_valid), .load_en(load_en), .load_addr(load_addr),
   .load_data(load_data), .issue(issue), .dump(dump)
);

// File: tb/tb_fetch.sv
// Fetch stage testbench
`timescale 1ns/1ps

module tb_fetch;

   localparam int PROG_WORDS = 16;
   localparam int RUN_CYCLES = 600;
   // Random phase plus the short drain to the halt, with wide margin
   localparam int LIMIT = 4000;
   // Redirect back before the tail words and the halt at the end
   localparam fetch_pkg::addr_t WRAP_PC = 16'd24;

   logic                clk;
   logic                rst;
   logic                redirect;
   fetch_pkg::addr_t    redirect_pc;
   fetch_pkg::reg_idx_t dst;
   logic                dst_valid;
   logic                load_en;
   fetch_pkg::addr_t    load_addr;
   fetch_pkg::word_t    load_data;
   fetch_pkg::issue_s   issue;
   logic                dump;
   integer              seed = 32'hb95e;
   int                  cycles = 0;

   clk_gen u_clk (.clk(clk), .rst(rst));

   fetch_stage #(
      .DEPTH_LOG2(8), .RAW_WINDOW(3), .JUMP_SHADOW(3), .BRANCH_SHADOW(2), .DUMP_DELAY(5)
   ) DUT (
      .clk(clk), .rst(rst), .redirect(redirect), .redirect_pc(redirect_pc),
      .dst(dst), .dst_valid(dst_valid), .load_en(load_en), .load_addr(load_addr),
      .load_data(load_data), .issue(issue), .dump(dump)
   );

   // Halt in the last slot, a jump and a branch always present
   function automatic fetch_pkg::word_t program_word(int slot, logic [31:0] r);
      if (slot == PROG_WORDS - 1) return {5'b00000, r[10:0]};
      if ((slot == 2) || (r[18:16] == 3'd0)) return {3'b001, r[12:0]};
      if ((slot == 6) || (r[18:16] == 3'd1)) return {3'b011, r[12:0]};
      // Top bit set gives a plain opcode, never the bubble word
      return {1'b1, r[14:0]};
   endfunction

   initial begin : stimulus
      logic [31:0] r;
      redirect    = 1'b0;
      redirect_pc = '0;
      dst         = '0;
      dst_valid   = 1'b0;
      load_en     = 1'b0;
      load_addr   = '0;
      load_data   = '0;
      // Program fill while reset is held
      for (int i = 0; i < PROG_WORDS; i++) begin
         r         = $random(seed);
         load_en   = 1'b1;
         load_addr = fetch_pkg::addr_t'(2 * i);
         load_data = program_word(i, r);
         @(negedge clk);
      end
      load_en = 1'b0;
      while (rst) @(negedge clk);

      // Random hazards, the wrap redirect and a few stray ones
      for (int n = 0; n < RUN_CYCLES; n++) begin
         r           = $random(seed);
         dst         = r[2:0];
         dst_valid   = (r[5:4] == 2'b00);
         redirect    = (issue.incr_pc >= WRAP_PC) || (r[11:8] == 4'h0);
         redirect_pc = fetch_pkg::addr_t'((r[15:12] % 12) * 2);
         @(negedge clk);
      end

      // Run on to the halt
      redirect = 1'b0;
      while (!dump) begin
         r         = $random(seed);
         dst       = r[2:0];
         dst_valid = (r[5:4] == 2'b00);
         @(negedge clk);
      end
      repeat (20) @(negedge clk);

      if (DUT.chk.errors == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         $display("TEST FAILED");
         $fatal(1, "fetch checks failed");
      end
   end

   // Stop at the first failed check
   always @(negedge clk) begin
      if (DUT.chk.errors != 0) begin
         $display("FAIL at %0t: a check on the fetch outputs saw a wrong value", $time);
         $display("TEST FAILED");
         $fatal(1, "fetch check failed");
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("Timeout after %0d cycles, the halt was never reached", cycles);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

endmodule

// File: vlog.f
hdl/fetch_pkg.sv
hdl/instr_mem.sv
hdl/pc_unit.sv
hdl/raw_detector.sv
hdl/flow_sequencer.sv
hdl/issue_ctrl.sv
hdl/fetch_stage.sv
tb/clk_gen.sv
tb/fetch_assert.sv
tb/tb_fetch.sv
